/* logic/audio_pkg.sv */
// audio playback package
// widths, word and address types, and the channel config and fetch request structs

package audio_pkg;

    localparam int ADDR_W   = 16;   // sample memory address width
    localparam int SAMPLE_W = 8;    // sample and dac code width

    // one 16-bit sample memory word, two signed samples, high byte first
    typedef logic [15:0] word_t;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef logic [SAMPLE_W-1:0] dac_code_t;    // unsigned, 8'h80 is silence

    // settings for the single channel, held as levels by the register block
    typedef struct packed {
        logic        enable;
        logic [15:0] vol;       // [15:8] left, [7:0] right
        logic [14:0] period;    // cycles between samples, minus two
        logic        tile;      // 0 selects video ram, 1 tile ram
        addr_t       start;
        logic [14:0] len;       // words per loop, minus one
        logic        restart;   // one cycle strobe
    } audio_chan_cfg_t;

    // memory request presented to the arbiter
    typedef struct packed {
        logic  tile;
        addr_t addr;
    } audio_fetch_t;

endpackage

/* logic/audio_fetch_fsm.sv */
// audio fetch FSM
// raises the memory fetch request, holds it until ack and passes the word to the buffer

`timescale 1ns/1ps

module audio_fetch_fsm (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    want_word_i,
    input  logic                    empty_i,
    input  audio_pkg::audio_fetch_t req_i,
    input  logic                    ack_i,
    input  audio_pkg::word_t        word_i,
    output logic                    fetch_o,
    output audio_pkg::audio_fetch_t req_o,
    output logic                    word_load_o,
    output audio_pkg::word_t        word_o,
    output logic                    fetch_done_o
);
    import audio_pkg::*;

    typedef enum logic {
        ST_REQ  = 1'b0,
        ST_READ = 1'b1
    } fetch_state_t;

    fetch_state_t state_q;
    audio_fetch_t req_q;
    word_t        word_q;
    logic         fetch_q;
    logic         load_q;
    logic         ack_hit;

    assign ack_hit      = (state_q == ST_READ) && fetch_q && ack_i;
    assign fetch_done_o = ack_hit;     // lets the timer drop want_word on the ack cycle
    assign fetch_o      = fetch_q;
    assign req_o        = req_q;
    assign word_load_o  = load_q;
    assign word_o       = word_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_REQ;
            fetch_q <= 1'b0;
            req_q   <= '0;
            load_q  <= 1'b0;
        end else begin
            load_q <= ack_hit;
            case (state_q)
                ST_REQ: begin
                    // only start when the buffer has played out both bytes
                    if (want_word_i && empty_i) begin
                        fetch_q <= 1'b1;
                    end
                    req_q   <= req_i;       // frozen while in read
                    state_q <= ST_READ;
                end
                ST_READ: begin
                    if (!fetch_q || ack_i) begin
                        fetch_q <= 1'b0;
                        state_q <= ST_REQ;
                    end
                end
                default: begin
                    state_q <= ST_REQ;
                end
            endcase
        end
    end

    // word is valid from the arbiter only in the ack cycle
    always_ff @(posedge clk) begin
        if (ack_hit) begin
            word_q <= word_i;
        end
    end

endmodule

/* logic/audio_channel_timer.sv */
// audio channel timer
// counts down the playback period and steps the sample address through one loop

`timescale 1ns/1ps

module audio_channel_timer (
    input  logic                       clk,
    input  logic                       reset_i,
    input  audio_pkg::audio_chan_cfg_t cfg_i,
    input  logic                       fetch_done_i,
    output logic                       emit_o,
    output logic                       want_word_o,
    output audio_pkg::audio_fetch_t    req_o,
    output logic                       reload_o
);
    import audio_pkg::*;

    logic [15:0]  period_q;     // bit 15 flags underflow
    logic [15:0]  length_q;     // words left in this loop
    logic [15:0]  length_n;
    logic         second_q;     // next emit plays the low byte
    logic         want_q;
    logic         restart;
    audio_fetch_t cur_q;

    assign length_n = length_q - 16'd1;
    assign restart  = length_n[15] || cfg_i.restart;   // loop done or forced

    // period underflow or forced restart
    assign emit_o      = period_q[15] || cfg_i.restart;
    assign want_word_o = want_q;
    assign req_o       = cur_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            period_q <= '0;
            length_q <= '0;
            second_q <= 1'b0;
            want_q   <= 1'b0;
            cur_q    <= '0;
            reload_o <= 1'b0;
        end else begin
            reload_o <= 1'b0;
            if (cfg_i.enable) begin
                period_q <= period_q - 16'd1;
            end

            if (emit_o) begin
                // a disabled channel reloads with the underflow bit set and idles
                period_q <= {!cfg_i.enable, cfg_i.period};
                second_q <= cfg_i.restart ? 1'b1 : !second_q;

                // first byte of a word, so line up the next word address
                if (!second_q || cfg_i.restart) begin
                    want_q <= cfg_i.enable;
                    if (restart) begin
                        cur_q.tile <= cfg_i.tile;
                        cur_q.addr <= cfg_i.start;
                        length_q   <= {1'b0, cfg_i.len};
                        reload_o   <= 1'b1;
                    end else begin
                        cur_q.addr <= cur_q.addr + ADDR_W'(1);
                        length_q   <= length_n;
                    end
                end
            end

            if (fetch_done_i) begin
                want_q <= 1'b0;
            end
        end
    end

endmodule

/* logic/audio_sample_buffer.sv */
// audio sample buffer
// holds one fetched word and plays its two bytes out as the channel value

`timescale 1ns/1ps

module audio_sample_buffer (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               enable_i,
    input  logic               emit_i,
    input  logic               word_load_i,
    input  audio_pkg::word_t   word_i,
    output logic               empty_o,
    output audio_pkg::sample_t chan_val_o
);
    import audio_pkg::*;

    word_t      buf_q;
    logic [1:0] valid_q;    // [1] high byte, [0] low byte
    sample_t    val_q;

    assign empty_o    = (valid_q == 2'b00);
    assign chan_val_o = val_q;

    // byte data, a stale word just keeps replaying its low byte
    always_ff @(posedge clk) begin
        if (word_load_i) begin
            buf_q <= word_i;
        end else if (emit_i) begin
            buf_q[15:8] <= buf_q[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 2'b00;
            val_q   <= '0;
        end else begin
            if (word_load_i) begin
                valid_q <= 2'b11;
            end else if (emit_i) begin
                valid_q <= {valid_q[0], 1'b0};
            end

            if (!enable_i) begin
                val_q <= '0;            // silence
            end else if (emit_i) begin
                val_q <= sample_t'(buf_q[15:8]);
            end
        end
    end

endmodule

/* logic/audio_volume_mixer.sv */
// audio volume mixer
// scales the channel value by left and right volume and converts to unsigned dac codes

`timescale 1ns/1ps

module audio_volume_mixer (
    input  logic                 clk,
    input  logic                 reset_i,
    input  audio_pkg::sample_t   chan_val_i,
    input  audio_pkg::word_t     vol_i,
    output audio_pkg::dac_code_t code_l_o,
    output audio_pkg::dac_code_t code_r_o
);
    import audio_pkg::*;

    typedef enum logic {
        ST_MULT = 1'b0,
        ST_CONV = 1'b1
    } mix_state_t;

    mix_state_t                    state_q;
    sample_t                       sample_q;
    logic signed [SAMPLE_W-1:0]    vol_l_q;     // 0..127
    logic signed [SAMPLE_W-1:0]    vol_r_q;
    logic signed [2*SAMPLE_W-1:0]  prod_l;
    logic signed [2*SAMPLE_W-1:0]  prod_r;

    // clip when the top two bits disagree, else take bits 13..6 with sign flipped
    function automatic dac_code_t to_code(input logic signed [2*SAMPLE_W-1:0] p);
        dac_code_t code;
        if (p[15] != p[14]) begin
            code = p[15] ? 8'h00 : 8'hFF;
        end else begin
            code = {~p[13], p[12:6]};
        end
        return code;
    endfunction

    assign prod_l = sample_q * vol_l_q;
    assign prod_r = sample_q * vol_r_q;

    // operands are captured in the multiply state only
    always_ff @(posedge clk) begin
        if (state_q == ST_MULT) begin
            sample_q <= chan_val_i;
            vol_l_q  <= {1'b0, vol_i[15:9]};
            vol_r_q  <= {1'b0, vol_i[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q  <= ST_MULT;
            code_l_o <= '0;
            code_r_o <= '0;
        end else begin
            case (state_q)
                ST_MULT: state_q <= ST_CONV;
                ST_CONV: begin
                    code_l_o <= to_code(prod_l);
                    code_r_o <= to_code(prod_r);
                    state_q  <= ST_MULT;
                end
                default: state_q <= ST_MULT;
            endcase
        end
    end

endmodule

/* logic/audio_pdm_dac.sv */
// first-order pulse-density dac
// accumulates the code each cycle and outputs the registered carry

`timescale 1ns/1ps

module audio_pdm_dac (
    input  logic                 clk,
    input  logic                 reset_i,
    input  audio_pkg::dac_code_t code_i,
    output logic                 pdm_o
);
    import audio_pkg::*;

    logic [SAMPLE_W-1:0] acc_q;

    // code ones out of every 256 cycles
    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc_q <= '0;
            pdm_o <= 1'b0;
        end else begin
            {pdm_o, acc_q} <= {1'b0, acc_q} + {1'b0, code_i};
        end
    end

endmodule

/* logic/audio_top.sv */
// audio playback top
// one channel from sample memory fetch through volume mixing to two pdm outputs

`timescale 1ns/1ps

module audio_top (
    input  logic                       clk,
    input  logic                       reset_i,
    input  audio_pkg::audio_chan_cfg_t cfg_i,
    input  logic                       ack_i,
    input  audio_pkg::word_t           word_i,
    output logic                       fetch_o,
    output audio_pkg::audio_fetch_t    req_o,
    output logic                       reload_o,
    output logic                       pdm_l_o,
    output logic                       pdm_r_o
);
    import audio_pkg::*;

    logic         emit;
    logic         want_word;
    logic         fetch_done;
    logic         word_load;
    logic         empty;
    audio_fetch_t timer_req;    // current address from the timer
    word_t        load_word;
    sample_t      chan_val;
    dac_code_t    code_l;
    dac_code_t    code_r;

    audio_channel_timer u_timer (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_i        (cfg_i),
        .fetch_done_i (fetch_done),
        .emit_o       (emit),
        .want_word_o  (want_word),
        .req_o        (timer_req),
        .reload_o     (reload_o)
    );

    audio_fetch_fsm u_fetch (
        .clk          (clk),
        .reset_i      (reset_i),
        .want_word_i  (want_word),
        .empty_i      (empty),
        .req_i        (timer_req),
        .ack_i        (ack_i),
        .word_i       (word_i),
        .fetch_o      (fetch_o),
        .req_o        (req_o),
        .word_load_o  (word_load),
        .word_o       (load_word),
        .fetch_done_o (fetch_done)
    );

    audio_sample_buffer u_buffer (
        .clk         (clk),
        .reset_i     (reset_i),
        .enable_i    (cfg_i.enable),
        .emit_i      (emit),
        .word_load_i (word_load),
        .word_i      (load_word),
        .empty_o     (empty),
        .chan_val_o  (chan_val)
    );

    audio_volume_mixer u_mixer (
        .clk        (clk),
        .reset_i    (reset_i),
        .chan_val_i (chan_val),
        .vol_i      (cfg_i.vol),
        .code_l_o   (code_l),
        .code_r_o   (code_r)
    );

    audio_pdm_dac dac_l (
        .clk     (clk),
        .reset_i (reset_i),
        .code_i  (code_l),
        .pdm_o   (pdm_l_o)
    );

    audio_pdm_dac dac_r (
        .clk     (clk),
        .reset_i (reset_i),
        .code_i  (code_r),
        .pdm_o   (pdm_r_o)
    );

endmodule

/* tb/audio_tb.sv */
// audio playback testbench
// reads test vectors, models the memory arbiter and counts pdm pulses against expected values

`timescale 1ns/1ps

module audio_tb;
    import audio_pkg::*;

    logic            clk;
    logic            reset_i;
    audio_chan_cfg_t cfg;
    logic            ack_i;
    word_t           word_i;
    logic            fetch_o;
    audio_fetch_t    req_o;
    logic            reload_o;
    logic            pdm_l_o;
    logic            pdm_r_o;

    int           errors;
    int           test_err;
    int           fetch_n;      // fetches started since the last reset
    int           reload_n;     // reload pulses since the last fetch started
    int           hold_err;     // fetch_o dropped or req_o moved while waiting for ack
    int           hold_cycles;  // extra ack delay for the first fetch of a test
    logic [7:0]   pattern;
    logic [31:0]  lfsr;
    audio_fetch_t req_q[$];
    int           reload_q[$];  // reloads seen just before each fetch

    audio_top dut_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .cfg_i    (cfg),
        .ack_i    (ack_i),
        .word_i   (word_i),
        .fetch_o  (fetch_o),
        .req_o    (req_o),
        .reload_o (reload_o),
        .pdm_l_o  (pdm_l_o),
        .pdm_r_o  (pdm_r_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 32'h8020_0003;
        end
        return s;
    endfunction

    // arbiter model, answers each fetch after a random delay of 0..7 cycles
    // and the first fetch of a test can be held back much longer
    initial begin : memory_model
        logic         busy;
        int           wait_n;
        audio_fetch_t held;
        busy = 1'b0;
        wait_n = 0;
        forever begin
            @(negedge clk);
            if (reload_o) reload_n++;
            if (ack_i) begin
                ack_i = 1'b0;
                busy  = 1'b0;
            end else if (busy && !fetch_o) begin
                if (!reset_i) hold_err++;   // dropped before any ack
                busy = 1'b0;
            end else if (fetch_o) begin
                if (!busy) begin
                    busy = 1'b1;
                    held = req_o;
                    req_q.push_back(req_o);
                    reload_q.push_back(reload_n);
                    reload_n = 0;
                    wait_n = 0;
                    for (int b = 0; b < 3; b++) begin
                        wait_n = wait_n | (int'(lfsr[0]) << b);
                        lfsr = lfsr_next(lfsr);
                    end
                    if (fetch_n == 0 && hold_cycles > 0) wait_n += hold_cycles;
                    fetch_n++;
                end
                if (req_o !== held) hold_err++;
                if (wait_n == 0) begin
                    ack_i  = 1'b1;
                    word_i = {pattern, pattern};
                end else begin
                    wait_n--;
                end
            end
        end
    end

    task automatic compare_value(input string name, input string what,
                                 input int exp, input int act);
        if (exp !== act) begin
            $display("[FAIL] %s %s expected %0d actual %0d", name, what, exp, act);
            errors++;
            test_err++;
        end
    endtask

    task automatic wait_fetch(input logic level, input int limit, input string name);
        int i;
        for (i = 0; i < limit; i++) begin
            @(negedge clk);
            if (fetch_o === level) break;
        end
        if (i == limit) begin
            $display("%s: timed out waiting for fetch_o to go %0b", name, level);
            errors++;
            test_err++;
        end
    endtask

    task automatic apply_reset();
        cfg = '0;
        reset_i = 1'b1;
        repeat (10) @(negedge clk);
        req_q.delete();
        reload_q.delete();
        fetch_n = 0;
        hold_err = 0;
        reload_n = 0;
        reset_i = 1'b0;
    endtask

    // loads a known word so the buffer never plays an unknown byte later
    task automatic prime_buffer();
        apply_reset();
        pattern = 8'h00;
        cfg.enable = 1'b1;
        wait_fetch(1'b1, 100, "prime");
        wait_fetch(1'b0, 100, "prime");
    endtask

    task automatic run_test(input string name, input int en, input int vol, input int period,
                            input int start, input int len, input int tile, input int pat,
                            input int hold, input int exp_l, input int exp_r, input int exp_a);
        int cl, cr, bad, seq_bad, distinct, n, i;
        test_err = 0;
        hold_cycles = hold;
        apply_reset();
        bad = 0;
        for (i = 0; i < 16; i++) begin
            @(negedge clk);
            if (i == 0 && (pdm_l_o || pdm_r_o)) bad++;
            if (fetch_o || reload_o) bad++;
        end
        compare_value(name, "idle_outputs", 0, bad);
        pattern = pat[7:0];
        cfg.vol = vol[15:0];
        cfg.period = period[14:0];
        cfg.start = start[15:0];
        cfg.len = len[14:0];
        cfg.tile = tile[0];
        cfg.enable = en[0];
        if (en != 0) begin
            wait_fetch(1'b1, 100, name);
            wait_fetch(1'b0, hold + 100, name);
        end
        repeat (2 * period + 16) @(negedge clk);
        cl = 0;
        cr = 0;
        for (i = 0; i < 256; i++) begin
            @(negedge clk);
            cl += pdm_l_o;
            cr += pdm_r_o;
        end
        compare_value(name, "left_count", exp_l, cl);
        compare_value(name, "right_count", exp_r, cr);
        distinct = 0;
        bad = 0;
        seq_bad = 0;
        foreach (req_q[k]) begin
            n = 1;
            for (int j = 0; j < k; j++) begin
                if (req_q[j].addr == req_q[k].addr) n = 0;
            end
            distinct += n;
            if (16'(req_q[k].addr - start[15:0]) > len || req_q[k].tile != tile[0]) bad++;
            // without back-pressure every word is fetched in order with one reload per loop
            if (hold == 0) begin
                if (req_q[k].addr != 16'(start + k % (len + 1))) seq_bad++;
                if (reload_q[k] != int'(req_q[k].addr == 16'(start))) seq_bad++;
            end
        end
        compare_value(name, "distinct_addrs", exp_a, distinct);
        compare_value(name, "addr_or_tile_errors", 0, bad);
        compare_value(name, "sequence_errors", 0, seq_bad);
        compare_value(name, "hold_errors", 0, hold_err);
        if (en != 0) begin
            compare_value(name, "first_addr", start, int'(req_q[0].addr));
            wait_fetch(1'b1, 8 * period + 100, name);
            wait_fetch(1'b0, 100, name);
            @(negedge clk);     // restart once the fetched word sits in the buffer
            n = fetch_n;
            cfg.restart = 1'b1;
            @(negedge clk);
            cfg.restart = 1'b0;
            compare_value(name, "restart_reload", 1, int'(reload_o));
            for (i = 0; i < 8 * period + 100 && fetch_n <= n; i++) @(negedge clk);
            if (fetch_n <= n) begin
                $display("%s: no fetch started after restart", name);
                errors++;
                test_err++;
            end else begin
                compare_value(name, "restart_addr", start, int'(req_q[n].addr));
            end
        end
        $display("%s %s", test_err == 0 ? "[PASS]" : "[DONE]", name);
    endtask

    initial begin : main
        int    fd, tests, nf;
        int    en, vol, period, start, len, tile, pat, hold, exp_l, exp_r, exp_a;
        string line, name;
        reset_i = 1'b1;
        cfg = '0;
        ack_i = 1'b0;
        word_i = '0;
        pattern = '0;
        hold_cycles = 0;
        lfsr = 32'h40a0_7ad7;
        errors = 0;
        tests = 0;
        fd = $fopen("tb/audio_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            errors++;
        end else begin
            prime_buffer();
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") continue;
                nf = $sscanf(line, "%s %d %h %d %h %d %d %h %d %d %d %d", name, en, vol, period,
                             start, len, tile, pat, hold, exp_l, exp_r, exp_a);
                if (nf != 12) begin
                    $display("malformed vector line: %s", line);
                    errors++;
                    continue;
                end
                run_test(name, en, vol, period, start, len, tile, pat, hold, exp_l, exp_r, exp_a);
                tests++;
            end
            $fclose(fd);
        end
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* tb/audio_vectors.txt */
# name enable vol(hex) period start(hex) len tile pattern(hex) hold
# exp_left exp_right exp_distinct_addrs   (counts are pdm ones per 256 cycles)
zero_vol     1 0000 10 0100 3 0 40 0   128 128 4
left_only    1 ff00 10 0200 2 1 40 0   255 128 3
mid_vol      1 8080 10 0300 4 0 20 0   160 160 5
pos_full     1 ffff 10 0400 1 0 7f 0   124 124 2
neg_full     1 ffff 10 0500 1 1 80 0   130 130 2
neg_left     1 ff00 10 0600 2 0 c0 0   1   128 3
zero_sample  1 ffff 10 0700 0 0 00 0   128 128 1
backpressure 1 8080 12 0800 3 1 20 200 160 160 4
disabled     0 ffff 10 0900 3 0 40 0   128 128 0

/* sim.f */
logic/audio_pkg.sv
logic/audio_fetch_fsm.sv
logic/audio_channel_timer.sv
logic/audio_sample_buffer.sv
logic/audio_volume_mixer.sv
logic/audio_pdm_dac.sv
logic/audio_top.sv
tb/audio_tb.sv
